//--- src/mmc5_pkg.sv
// MMC5 mapper package: register map, mode encodings, CPU bus and configuration structs
`default_nettype none

package mmc5_pkg;

	// Output address widths
	localparam int PRG_AW = 22; // PRG ROM/RAM address, 8 kB pages
	localparam int CHR_AW = 22; // CHR ROM address, 1 kB pages

	// Register window $5000-$53FF
	localparam logic [5:0] REG_BASE_HI = 6'b010100;

	// Register offsets inside the window
	localparam logic [9:0] REG_PRG_MODE  = 10'h100;
	localparam logic [9:0] REG_CHR_MODE  = 10'h101;
	localparam logic [9:0] REG_PROTECT_1 = 10'h102; // Key 1, must be %10
	localparam logic [9:0] REG_PROTECT_2 = 10'h103; // Key 2, must be %01
	localparam logic [9:0] REG_MIRROR    = 10'h105;
	localparam logic [9:0] REG_PRG_RAM   = 10'h113; // $6000-$7FFF RAM bank
	localparam logic [9:0] REG_PRG_BANK0 = 10'h114; // Banks 0..3 at $5114-$5117
	localparam logic [9:0] REG_CHR_BANK0 = 10'h120; // Banks 0..7 at $5120-$5127
	localparam logic [9:0] REG_UPPER_CHR = 10'h130;
	localparam logic [9:0] REG_IRQ_LINE  = 10'h203;
	localparam logic [9:0] REG_IRQ_STAT  = 10'h204; // Write: IRQ enable, read: status
	localparam logic [9:0] REG_MUL_LO    = 10'h205;
	localparam logic [9:0] REG_MUL_HI    = 10'h206;

	// PRG banking modes ($5100)
	localparam logic [1:0] PRG_MODE_32K   = 2'd0;
	localparam logic [1:0] PRG_MODE_16K   = 2'd1;
	localparam logic [1:0] PRG_MODE_16_8K = 2'd2;
	localparam logic [1:0] PRG_MODE_8K    = 2'd3;

	// CHR banking modes ($5101)
	localparam logic [1:0] CHR_MODE_8K = 2'd0;
	localparam logic [1:0] CHR_MODE_4K = 2'd1;
	localparam logic [1:0] CHR_MODE_2K = 2'd2;
	localparam logic [1:0] CHR_MODE_1K = 2'd3;

	localparam logic [5:0] PRG_RAM_PAGE_BASE = 6'b111100; // PRG RAM lives at the top of PRG space
	localparam logic [1:0] CHR_PAGE_BASE     = 2'b10;
	localparam logic [1:0] NT_REGION         = 2'b10;     // PPU $2000-$2FFF

	// One CPU bus cycle
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        wr;
		logic        rd;
	} cpu_bus_t;

	// Mapper configuration as written by the CPU
	typedef struct packed {
		logic [1:0]       prg_mode;
		logic [1:0]       chr_mode;
		logic             prg_protect_1;
		logic             prg_protect_2;
		logic [7:0]       mirroring;      // Two bits per nametable quadrant
		logic [2:0]       prg_ram_bank;
		logic [7:0]       prg_bank_0;     // Bit 7 set selects ROM
		logic [7:0]       prg_bank_1;
		logic [7:0]       prg_bank_2;
		logic [6:0]       prg_bank_3;     // Always ROM
		logic [7:0][9:0]  chr_bank;       // Sprite set $5120-$5127
		logic [1:0]       upper_chr_bits;
		logic [7:0]       irq_scanline;
		logic             irq_enable;
	} mmc5_cfg_t;

endpackage

`default_nettype wire

//--- src/mmc5_regs.sv
// MMC5 register block: CPU write decode, configuration registers, multiplier, read mux
`timescale 1ns/1ps
`default_nettype none

module mmc5_regs import mmc5_pkg::*; (
	input  wire        clk,
	input  wire        rst_n_i,
	input  wire        cpu_ce_i,      // One pulse per CPU cycle
	input  cpu_bus_t   cpu_i,
	input  wire        in_frame_i,    // From scanline detector
	input  wire        irq_pending_i,
	output mmc5_cfg_t  cfg_o,
	output logic       stat_read_o,   // $5204 read on this CPU cycle
	output logic [7:0] prg_dout_o,
	output logic       prg_drive_o
);

	mmc5_cfg_t   cfg_q;
	logic [7:0]  mul_a_q;            // $5205 operand
	logic [7:0]  mul_b_q;            // $5206 operand
	logic [15:0] product;
	logic        reg_wr;             // Write into $5000-$53FF

	assign reg_wr  = cpu_ce_i & cpu_i.wr & (cpu_i.addr[15:10] == REG_BASE_HI);
	assign product = mul_a_q * mul_b_q; // 8x8 unsigned

	// Configuration and operand registers
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cfg_q            <= '0;
			cfg_q.prg_mode   <= PRG_MODE_8K; // Boot in 8 kB mode
			cfg_q.prg_bank_3 <= 7'h7F;       // Last ROM page holds the vectors
			mul_a_q          <= '0;
			mul_b_q          <= '0;
		end else if (reg_wr) begin
			case (cpu_i.addr[9:0])
				REG_PRG_MODE:  cfg_q.prg_mode <= cpu_i.data[1:0];
				REG_CHR_MODE:  cfg_q.chr_mode <= cpu_i.data[1:0];
				REG_PROTECT_1: cfg_q.prg_protect_1 <= (cpu_i.data[1:0] == 2'b10);
				REG_PROTECT_2: cfg_q.prg_protect_2 <= (cpu_i.data[1:0] == 2'b01);
				REG_MIRROR:    cfg_q.mirroring <= cpu_i.data;
				REG_PRG_RAM:   cfg_q.prg_ram_bank <= cpu_i.data[2:0];
				REG_PRG_BANK0:          cfg_q.prg_bank_0 <= cpu_i.data;
				REG_PRG_BANK0 + 10'd1:  cfg_q.prg_bank_1 <= cpu_i.data;
				REG_PRG_BANK0 + 10'd2:  cfg_q.prg_bank_2 <= cpu_i.data;
				REG_PRG_BANK0 + 10'd3:  cfg_q.prg_bank_3 <= cpu_i.data[6:0]; // Bit 7 ignored
				REG_UPPER_CHR: cfg_q.upper_chr_bits <= cpu_i.data[1:0];
				REG_IRQ_LINE:  cfg_q.irq_scanline <= cpu_i.data;
				REG_IRQ_STAT:  cfg_q.irq_enable <= cpu_i.data[7];
				REG_MUL_LO:    mul_a_q <= cpu_i.data;
				REG_MUL_HI:    mul_b_q <= cpu_i.data;
				default: begin
				end
			endcase
			// CHR banks $5120-$5127, upper bits come from $5130
			if (cpu_i.addr[9:3] == REG_CHR_BANK0[9:3])
				cfg_q.chr_bank[cpu_i.addr[2:0]] <= {cfg_q.upper_chr_bits, cpu_i.data};
		end
	end

	assign cfg_o = cfg_q;

	// Status read strobe, consumed by the IRQ clear logic
	assign stat_read_o = cpu_ce_i & cpu_i.rd & (cpu_i.addr == {REG_BASE_HI, REG_IRQ_STAT});

	// CPU read data
	always_comb begin
		prg_drive_o = 1'b1;
		case (cpu_i.addr)
			{REG_BASE_HI, REG_IRQ_STAT}: prg_dout_o = {irq_pending_i, in_frame_i, 6'b111111};
			{REG_BASE_HI, REG_MUL_LO}:   prg_dout_o = product[7:0];
			{REG_BASE_HI, REG_MUL_HI}:   prg_dout_o = product[15:8];
			default: begin
				prg_dout_o  = 8'hFF; // Open bus
				prg_drive_o = 1'b0;
			end
		endcase
	end

	// Configuration only moves on a CPU write into the register window
	a_cfg_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		!reg_wr |=> $stable(cfg_q));

endmodule

`default_nettype wire

//--- src/mmc5_prg_map.sv
// MMC5 PRG mapping: page select per PRG mode, PRG output address, access permission
`timescale 1ns/1ps
`default_nettype none

module mmc5_prg_map import mmc5_pkg::*; (
	input  wire [15:0]       cpu_addr_i,
	input  wire              cpu_wr_i,
	input  mmc5_cfg_t        cfg_i,
	output logic [PRG_AW-1:0] prg_addr_o,
	output logic             prg_allow_o
);

	logic [7:0] page;   // Bit 7 set means ROM
	logic       ram_we; // Both protect keys written

	// 8 kB page select from mode and A15..A13
	always_comb begin
		page = {5'b00000, cfg_i.prg_ram_bank}; // $0000-$7FFF, RAM bank
		if (cpu_addr_i[15]) begin
			case (cfg_i.prg_mode)
				PRG_MODE_32K:
					page = {1'b1, cfg_i.prg_bank_3[6:2], cpu_addr_i[14:13]};
				PRG_MODE_16K:
					if (!cpu_addr_i[14])
						page = {cfg_i.prg_bank_1[7:1], cpu_addr_i[13]};      // $8000-$BFFF
					else
						page = {1'b1, cfg_i.prg_bank_3[6:1], cpu_addr_i[13]}; // $C000-$FFFF
				PRG_MODE_16_8K:
					if (!cpu_addr_i[14])
						page = {cfg_i.prg_bank_1[7:1], cpu_addr_i[13]};
					else if (!cpu_addr_i[13])
						page = cfg_i.prg_bank_2;                        // $C000-$DFFF
					else
						page = {1'b1, cfg_i.prg_bank_3};                // $E000-$FFFF
				PRG_MODE_8K:
					case (cpu_addr_i[14:13])
						2'd0: page = cfg_i.prg_bank_0;
						2'd1: page = cfg_i.prg_bank_1;
						2'd2: page = cfg_i.prg_bank_2;
						default: page = {1'b1, cfg_i.prg_bank_3};
					endcase
				default: begin
				end
			endcase
		end
	end

	// ROM pages from 0, RAM pages at the top of the space, 8 kB windows
	assign prg_addr_o = {page[7] ? {2'b00, page[6:0]} : {PRG_RAM_PAGE_BASE, page[2:0]},
		cpu_addr_i[12:0]};

	assign ram_we = cfg_i.prg_protect_1 & cfg_i.prg_protect_2;

	// Reads anywhere from $6000, writes only to unprotected RAM
	assign prg_allow_o = (cpu_addr_i >= 16'h6000) && (!cpu_wr_i || (!page[7] && ram_we));

endmodule

`default_nettype wire

//--- src/mmc5_chr_map.sv
// MMC5 CHR mapping: 1 kB page select per CHR mode, CHR output address, nametable mirroring
`timescale 1ns/1ps
`default_nettype none

module mmc5_chr_map import mmc5_pkg::*; (
	input  wire [13:0]        chr_addr_i, // PPU address
	input  mmc5_cfg_t         cfg_i,
	output logic [CHR_AW-1:0] chr_addr_o,
	output logic              vram_a10_o,
	output logic              vram_ce_o
);

	logic [9:0] page;     // 1 kB CHR page
	logic [1:0] mirr_sel; // Mirroring pair for this quadrant

	// Page select from mode and A12..A10
	always_comb begin
		case (cfg_i.chr_mode)
			CHR_MODE_8K:
				page = {cfg_i.chr_bank[7][6:0], chr_addr_i[12:10]};
			CHR_MODE_4K:
				if (!chr_addr_i[12])
					page = {cfg_i.chr_bank[3][7:0], chr_addr_i[11:10]}; // $0000-$0FFF
				else
					page = {cfg_i.chr_bank[7][7:0], chr_addr_i[11:10]}; // $1000-$1FFF
			CHR_MODE_2K:
				case (chr_addr_i[12:11])
					2'd0: page = {cfg_i.chr_bank[1][8:0], chr_addr_i[10]};
					2'd1: page = {cfg_i.chr_bank[3][8:0], chr_addr_i[10]};
					2'd2: page = {cfg_i.chr_bank[5][8:0], chr_addr_i[10]};
					default: page = {cfg_i.chr_bank[7][8:0], chr_addr_i[10]};
				endcase
			default:
				page = cfg_i.chr_bank[chr_addr_i[12:10]]; // CHR_MODE_1K, one bank per 1 kB
		endcase
	end

	assign chr_addr_o = {CHR_PAGE_BASE, page, chr_addr_i[9:0]};

	// Quadrant by A11..A10
	always_comb begin
		case (chr_addr_i[11:10])
			2'd0: mirr_sel = cfg_i.mirroring[1:0];
			2'd1: mirr_sel = cfg_i.mirroring[3:2];
			2'd2: mirr_sel = cfg_i.mirroring[5:4];
			default: mirr_sel = cfg_i.mirroring[7:6];
		endcase
	end

	// %00 VRAM page A, %01 page B, %1x not internal VRAM
	assign vram_a10_o = mirr_sel[0];
	assign vram_ce_o  = chr_addr_i[13] & ~mirr_sel[1];

endmodule

`default_nettype wire

//--- src/mmc5_scanline.sv
// MMC5 scanline detector: PPU read tracking, in-frame state, scanline counter, IRQ pending
`timescale 1ns/1ps
`default_nettype none

module mmc5_scanline import mmc5_pkg::*; #(
	parameter int NO_READ_LIMIT = 3 // CPU cycles without PPU read before leaving the frame
) (
	input  wire        clk,
	input  wire        rst_n_i,
	input  wire        cpu_ce_i,
	input  cpu_bus_t   cpu_i,
	input  wire [13:0] chr_addr_i,
	input  wire        chr_read_i,   // Level, high during a PPU read
	input  wire        stat_read_i,  // $5204 read strobe
	input  mmc5_cfg_t  cfg_i,
	output logic       in_frame_o,
	output logic       irq_pending_o,
	output logic       irq_o
);

	localparam int NR_W = $clog2(NO_READ_LIMIT + 1);

	logic            read_q;      // Previous read level
	logic [11:0]     last_nt_q;   // Address of the previous read start
	logic [1:0]      rep_cnt_q;   // Identical nametable reads in a row
	logic [NR_W-1:0] nr_cnt_q;    // CPU cycles since the last PPU read
	logic [7:0]      scanline_q;
	logic            in_frame_q;
	logic            pending_q;
	logic            clr_q;       // Status was read on the previous CPU cycle

	logic read_start;
	logic is_nt;
	logic armed;
	logic wrap;
	logic timeout;
	logic vec_read;
	logic leave;

	assign read_start = chr_read_i & ~read_q;
	assign is_nt      = (chr_addr_i[13:12] == NT_REGION);
	assign armed      = &rep_cnt_q;                 // Three matching reads seen
	assign wrap       = read_start & armed & in_frame_q & (scanline_q == 8'd239);
	assign timeout    = cpu_ce_i & ~chr_read_i & in_frame_q
		& (nr_cnt_q == NR_W'(NO_READ_LIMIT - 1));
	assign vec_read   = cpu_ce_i & cpu_i.rd & ({cpu_i.addr[15:1], 1'b0} == 16'hFFFA); // NMI vector
	assign leave      = wrap | timeout | vec_read;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			read_q     <= 1'b0;
			last_nt_q  <= '0;
			rep_cnt_q  <= '0;
			nr_cnt_q   <= '0;
			scanline_q <= '0;
			in_frame_q <= 1'b0;
			pending_q  <= 1'b0;
			clr_q      <= 1'b0;
		end else begin
			read_q <= chr_read_i;

			if (read_start) begin
				last_nt_q <= chr_addr_i[11:0];
				if (!armed)
					rep_cnt_q <= rep_cnt_q + 2'd1;
				else if (!in_frame_q) begin
					in_frame_q <= 1'b1; // First detected line
					scanline_q <= 8'd0;
				end else if (scanline_q != 8'd239) begin
					scanline_q <= scanline_q + 8'd1;
					if ((cfg_i.irq_scanline != 8'd0) && (scanline_q + 8'd1 == cfg_i.irq_scanline))
						pending_q <= 1'b1;
				end
				if (!is_nt)
					rep_cnt_q <= 2'd0; // Pattern fetch breaks the run
				else if ((rep_cnt_q != 2'd0) && (last_nt_q != chr_addr_i[11:0]))
					rep_cnt_q <= 2'd1; // New nametable address opens a run
			end

			if (chr_read_i)
				nr_cnt_q <= '0;
			else if (cpu_ce_i && in_frame_q)
				nr_cnt_q <= nr_cnt_q + 1'b1;

			// Pending clears one CPU cycle after the status read
			if (cpu_ce_i) begin
				if (clr_q)
					pending_q <= 1'b0;
				clr_q <= stat_read_i;
			end

			if (leave) begin
				in_frame_q <= 1'b0;
				pending_q  <= 1'b0;
				rep_cnt_q  <= 2'd0;
				nr_cnt_q   <= '0;
			end
		end
	end

	assign in_frame_o    = in_frame_q;
	assign irq_pending_o = pending_q;
	assign irq_o         = pending_q & cfg_i.irq_enable;

	// Line 239 always leaves the frame on the next count
	a_line_range: assert property (@(posedge clk) disable iff (!rst_n_i)
		in_frame_q |-> scanline_q <= 8'd239);

endmodule

`default_nettype wire

//--- src/mmc5_mapper.sv
// MMC5 mapper top level: register block, PRG and CHR mapping, scanline detector
`timescale 1ns/1ps
`default_nettype none

module mmc5_mapper import mmc5_pkg::*; #(
	parameter int NO_READ_LIMIT = 3
) (
	input  wire               clk,
	input  wire               rst_n_i,
	input  wire               cpu_ce_i,    // CPU cycle strobe
	input  cpu_bus_t          cpu_i,
	input  wire [13:0]        chr_addr_i,  // PPU address
	input  wire               chr_read_i,
	output logic [PRG_AW-1:0] prg_addr_o,
	output logic [7:0]        prg_dout_o,  // Mapper register read data
	output logic              prg_drive_o, // Mapper drives the CPU data bus
	output logic              prg_allow_o,
	output logic [CHR_AW-1:0] chr_addr_o,
	output logic              vram_a10_o,
	output logic              vram_ce_o,   // Route to internal 2 kB VRAM
	output logic              irq_o
);

	mmc5_cfg_t cfg;
	logic      in_frame;
	logic      irq_pending;
	logic      stat_read;

	mmc5_regs mmc5_regs_i (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.cpu_ce_i      (cpu_ce_i),
		.cpu_i         (cpu_i),
		.in_frame_i    (in_frame),
		.irq_pending_i (irq_pending),
		.cfg_o         (cfg),
		.stat_read_o   (stat_read),
		.prg_dout_o    (prg_dout_o),
		.prg_drive_o   (prg_drive_o)
	);

	mmc5_prg_map mmc5_prg_map_i (
		.cpu_addr_i  (cpu_i.addr),
		.cpu_wr_i    (cpu_i.wr),
		.cfg_i       (cfg),
		.prg_addr_o  (prg_addr_o),
		.prg_allow_o (prg_allow_o)
	);

	mmc5_chr_map mmc5_chr_map_i (
		.chr_addr_i (chr_addr_i),
		.cfg_i      (cfg),
		.chr_addr_o (chr_addr_o),
		.vram_a10_o (vram_a10_o),
		.vram_ce_o  (vram_ce_o)
	);

	mmc5_scanline #(
		.NO_READ_LIMIT (NO_READ_LIMIT)
	) mmc5_scanline_i (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.cpu_ce_i      (cpu_ce_i),
		.cpu_i         (cpu_i),
		.chr_addr_i    (chr_addr_i),
		.chr_read_i    (chr_read_i),
		.stat_read_i   (stat_read),
		.cfg_i         (cfg),
		.in_frame_o    (in_frame),
		.irq_pending_o (irq_pending),
		.irq_o         (irq_o)
	);

endmodule

`default_nettype wire

//--- verif/tb_mmc5_mapper.sv
// Testbench for mmc5_mapper: clock, reset, stimulus tasks, reference model, checker, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_mmc5_mapper import mmc5_pkg::*; ();

	localparam int CLK_PERIOD    = 10;
	localparam int NO_READ_LIMIT = 4;  // Room for three status-sequence reads inside the frame
	localparam int N_PRG         = 32; // PRG rounds
	localparam int N_CHR         = 24; // CHR rounds
	localparam int N_MUL         = 16; // Multiplier rounds
	localparam int OPS_TOTAL     = N_PRG * 13 + N_CHR * 22 + N_MUL * 4 + 128;

	logic              clk;
	logic              rst_n;
	logic              cpu_ce;
	cpu_bus_t          cpu_bus;
	logic [13:0]       chr_addr;
	logic              chr_read;
	logic [PRG_AW-1:0] prg_addr;
	logic [7:0]        prg_dout;
	logic              prg_drive;
	logic              prg_allow;
	logic [CHR_AW-1:0] chr_addr_out;
	logic              vram_a10;
	logic              vram_ce;
	logic              irq;
	int                n_checks;
	int                n_errors;

	// Shadow of the CPU-visible registers
	logic [1:0] s_prg_mode, s_chr_mode, s_upper;
	logic       s_key1, s_key2, s_irq_en;
	logic [7:0] s_mirror, s_irq_line, s_mul_a, s_mul_b;
	logic [2:0] s_ram_bank;
	logic [7:0] s_prg_bank [4];   // Bank 3 kept with its ROM bit set
	logic [9:0] s_chr_bank [8];
	// Scanline model state
	logic        m_in_frame, m_pending, m_clr;
	int          m_line, m_run, m_nr;
	logic [13:0] m_last_nt;

	mmc5_mapper #(
		.NO_READ_LIMIT (NO_READ_LIMIT)
	) mmc5_mapper_i (
		.clk (clk), .rst_n_i (rst_n), .cpu_ce_i (cpu_ce), .cpu_i (cpu_bus),
		.chr_addr_i (chr_addr), .chr_read_i (chr_read),
		.prg_addr_o (prg_addr), .prg_dout_o (prg_dout), .prg_drive_o (prg_drive),
		.prg_allow_o (prg_allow), .chr_addr_o (chr_addr_out), .vram_a10_o (vram_a10),
		.vram_ce_o (vram_ce), .irq_o (irq)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		#(OPS_TOTAL * 20 * CLK_PERIOD);
		$display("Watchdog expired: the test did not finish in %0d clock periods", OPS_TOTAL * 20);
		$display("sim failed");
		$finish;
	end

	task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string what);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("[ERROR] %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	// 8 kB page per PRG mode, bit 7 marks ROM
	function automatic logic [7:0] ref_prg_page(input logic [15:0] addr);
		logic [7:0] page;
		if (!addr[15])
			page = {5'b00000, s_ram_bank};
		else case (s_prg_mode)
			2'd0: page = {s_prg_bank[3][7:2], addr[14:13]};          // 32 kB
			2'd1: page = addr[14] ? {s_prg_bank[3][7:1], addr[13]}
				: {s_prg_bank[1][7:1], addr[13]};                      // 2x16 kB
			2'd2: page = !addr[14] ? {s_prg_bank[1][7:1], addr[13]}
				: (addr[13] ? s_prg_bank[3] : s_prg_bank[2]);
			default: page = s_prg_bank[addr[14:13]];                  // 4x8 kB
		endcase
		return page;
	endfunction

	function automatic logic [PRG_AW-1:0] ref_prg_addr(input logic [15:0] addr);
		logic [7:0] page;
		page = ref_prg_page(addr);
		if (page[7])
			return {2'b00, page[6:0], addr[12:0]};
		return {PRG_RAM_PAGE_BASE, page[2:0], addr[12:0]};
	endfunction

	function automatic logic ref_prg_allow(input logic [15:0] addr, input logic wr);
		logic [7:0] page;
		page = ref_prg_page(addr);
		return (addr >= 16'h6000) && (!wr || (!page[7] && s_key1 && s_key2));
	endfunction

	function automatic logic [CHR_AW-1:0] ref_chr_addr(input logic [13:0] addr);
		logic [9:0] page;
		case (s_chr_mode)
			2'd0: page = {s_chr_bank[7][6:0], addr[12:10]};
			2'd1: page = {s_chr_bank[addr[12] ? 3'd7 : 3'd3][7:0], addr[11:10]};
			2'd2: page = {s_chr_bank[{addr[12:11], 1'b1}][8:0], addr[10]};
			default: page = s_chr_bank[addr[12:10]];
		endcase
		return {CHR_PAGE_BASE, page, addr[9:0]};
	endfunction

	// {vram_ce, vram_a10} from the quadrant's mirroring pair
	function automatic logic [1:0] ref_vram(input logic [13:0] addr);
		logic [1:0] pair;
		pair = s_mirror[2 * addr[11:10] +: 2];
		return {addr[13] & ~pair[1], pair[0]};
	endfunction

	// {drive, data} seen by the CPU during a read cycle
	function automatic logic [8:0] ref_read(input logic [15:0] addr);
		logic [15:0] product;
		product = s_mul_a * s_mul_b;
		case (addr)
			16'h5204: return {1'b1, m_pending, m_in_frame, 6'h3F};
			16'h5205: return {1'b1, product[7:0]};
			16'h5206: return {1'b1, product[15:8]};
			default:  return {1'b0, 8'hFF}; // Open bus
		endcase
	endfunction

	task automatic shadow_reset();
		s_prg_mode = 2'd3;
		s_chr_mode = '0;
		s_upper    = '0;
		s_key1     = 0;
		s_key2     = 0;
		s_irq_en   = 0;
		s_mirror   = '0;
		s_irq_line = '0;
		s_mul_a    = '0;
		s_mul_b    = '0;
		s_ram_bank = '0;
		s_prg_bank = '{8'h00, 8'h00, 8'h00, 8'hFF};
		s_chr_bank = '{default: '0};
		m_in_frame = 0;
		m_pending  = 0;
		m_clr      = 0;
		m_line     = 0;
		m_run      = 0;
		m_nr       = 0;
		m_last_nt  = '0;
	endtask

	task automatic shadow_write(input logic [15:0] addr, input logic [7:0] data);
		case (addr)
			16'h5100: s_prg_mode = data[1:0];
			16'h5101: s_chr_mode = data[1:0];
			16'h5102: s_key1 = (data[1:0] == 2'b10);
			16'h5103: s_key2 = (data[1:0] == 2'b01);
			16'h5105: s_mirror = data;
			16'h5113: s_ram_bank = data[2:0];
			16'h5114, 16'h5115, 16'h5116: s_prg_bank[addr[1:0]] = data;
			16'h5117: s_prg_bank[3] = {1'b1, data[6:0]}; // Always ROM
			16'h5130: s_upper = data[1:0];
			16'h5203: s_irq_line = data;
			16'h5204: s_irq_en = data[7];
			16'h5205: s_mul_a = data;
			16'h5206: s_mul_b = data;
			default: begin
				if (addr[15:3] == 13'h0A24) // $5120-$5127
					s_chr_bank[addr[2:0]] = {s_upper, data};
			end
		endcase
	endtask

	task automatic frame_leave();
		m_in_frame = 0;
		m_pending  = 0;
		m_run      = 0;
		m_nr       = 0;
	endtask

	task automatic line_count();
		if (!m_in_frame) begin
			m_in_frame = 1;
			m_line     = 0;
		end else if (m_line == 239)
			frame_leave();
		else begin
			m_line++;
			if (s_irq_line != 0 && m_line == s_irq_line)
				m_pending = 1;
		end
	endtask

	// One PPU read start, three same nametable starts arm the next count
	task automatic ppu_start_update(input logic [13:0] addr);
		logic is_nt;
		logic counting;
		is_nt    = (addr[13:12] == 2'b10);
		counting = (m_run >= 3);
		m_nr     = 0;
		if (is_nt && m_run > 0 && addr == m_last_nt)
			m_run++;
		else
			m_run = is_nt ? 1 : 0;
		m_last_nt = addr;
		if (counting)
			line_count();
	endtask

	task automatic cpu_pulse_update(input logic [15:0] addr, input logic rd);
		if (m_clr)
			m_pending = 0; // Acknowledge lands one CPU cycle after the status read
		m_clr = rd && (addr == 16'h5204);
		if (m_in_frame) begin
			m_nr++;
			if (m_nr == NO_READ_LIMIT)
				frame_leave();
		end
		if (rd && addr[15:1] == 15'h7FFD) // $FFFA/$FFFB vector fetch
			frame_leave();
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk);
		cpu_ce  = 1'b1;
		cpu_bus = {addr, data, 1'b1, 1'b0};
		@(negedge clk);
		cpu_ce     = 1'b0;
		cpu_bus.wr = 1'b0;
		shadow_write(addr, data);
		cpu_pulse_update(addr, 1'b0);
	endtask

	task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
		logic [8:0] expected;
		@(negedge clk);
		cpu_ce  = 1'b1;
		cpu_bus = {addr, 8'h00, 1'b0, 1'b1};
		#(CLK_PERIOD / 2 - 1); // Just before the strobe edge
		data     = prg_dout;
		expected = ref_read(addr);
		check({prg_drive, prg_dout}, expected, "CPU read data");
		@(negedge clk);
		cpu_ce     = 1'b0;
		cpu_bus.rd = 1'b0;
		cpu_pulse_update(addr, 1'b1);
	endtask

	task automatic ppu_read(input logic [13:0] addr);
		@(negedge clk);
		chr_addr = addr;
		chr_read = 1'b1;
		@(negedge clk);
		chr_read = 1'b0;
		ppu_start_update(addr);
	endtask

	// Address only, no CPU strobe
	task automatic prg_probe(input logic [15:0] addr, input logic wr);
		@(negedge clk);
		cpu_bus = {addr, 8'h00, wr, 1'b0};
		#(CLK_PERIOD / 2 - 1);
		check(prg_addr, ref_prg_addr(addr), "PRG address");
		check(prg_allow, ref_prg_allow(addr, wr), "PRG access permission");
	endtask

	task automatic chr_probe(input logic [13:0] addr);
		@(negedge clk);
		chr_addr = addr;
		#(CLK_PERIOD / 2 - 1);
		check(chr_addr_out, ref_chr_addr(addr), "CHR address");
		check({vram_ce, vram_a10}, ref_vram(addr), "VRAM select");
	endtask

	// Three fetches of one nametable byte, then a pattern fetch
	task automatic scanline_group();
		logic [13:0] nt;
		nt = {2'b10, 12'($urandom)};
		repeat (3) ppu_read(nt);
		ppu_read(14'($urandom & 32'h1FFF));
		check(irq, m_pending & s_irq_en, "IRQ output");
	endtask

	initial begin : stimulus
		logic [7:0] a, b, lo, hi, stat;
		int         line_sel;
		void'($urandom(32'hdcb1_0f03));
		clk      = 1'b0;
		rst_n    = 1'b0;
		cpu_ce   = 1'b0;
		cpu_bus  = '0;
		chr_addr = '0;
		chr_read = 1'b0;
		n_checks = 0;
		n_errors = 0;
		shadow_reset();
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		// Reset state, vectors page in mode 3
		prg_probe(16'hE000, 1'b0);
		check(prg_addr[PRG_AW-1:13], 9'h07F, "PRG page after reset");
		check(irq, 1'b0, "IRQ after reset");
		check(prg_drive, 1'b0, "Data drive after reset");

		repeat (N_PRG) begin
			cpu_write(16'h5100, 8'($urandom));
			for (int i = 0; i < 4; i++)
				cpu_write(16'(16'h5114 + i), 8'($urandom));
			cpu_write(16'h5113, 8'($urandom));
			cpu_write(16'h5102, 8'h02 | 8'($urandom & 1)); // Key valid half the time
			cpu_write(16'h5103, 8'h01 | 8'($urandom & 2));
			repeat (4) prg_probe(16'($urandom), 1'($urandom)); // Below $6000 too
		end

		repeat (N_CHR) begin
			cpu_write(16'h5101, 8'($urandom));
			for (int i = 0; i < 8; i++) begin
				cpu_write(16'h5130, 8'($urandom));
				cpu_write(16'(16'h5120 + i), 8'($urandom));
			end
			cpu_write(16'h5105, 8'($urandom));
			repeat (2) chr_probe(14'($urandom & 32'h1FFF));            // Pattern tables
			repeat (2) chr_probe(14'h2000 | 14'($urandom & 32'h0FFF)); // Nametables
		end

		repeat (N_MUL) begin
			a = 8'($urandom);
			b = 8'($urandom);
			cpu_write(16'h5205, a);
			cpu_write(16'h5206, b);
			cpu_read(16'h5205, lo);
			cpu_read(16'h5206, hi);
			check({hi, lo}, 16'(a) * 16'(b), "Multiplier product");
		end

		// IRQ at a chosen scanline, then acknowledge
		line_sel = 3 + $urandom % 8;
		cpu_write(16'h5203, 8'(line_sel));
		cpu_write(16'h5204, 8'h80);
		for (int g = 0; g <= line_sel; g++)
			scanline_group();
		check(irq, 1'b1, "IRQ at target scanline");
		cpu_read(16'h5204, stat);
		check(stat[7:6], 2'b11, "Status with IRQ pending");
		cpu_read(16'h5205, stat); // Next CPU cycle applies the clear
		cpu_read(16'h5204, stat);
		check(stat[7], 1'b0, "Status after acknowledge");
		check(irq, 1'b0, "IRQ after acknowledge");

		// PPU goes idle for NO_READ_LIMIT CPU cycles
		scanline_group();
		cpu_read(16'h5204, stat);
		check(stat[6], 1'b1, "In frame before PPU idle");
		repeat (NO_READ_LIMIT - 1)
			cpu_read(16'h8000 | 16'($urandom & 32'h3FFF), stat);
		cpu_read(16'h5204, stat);
		check(stat[6], 1'b0, "In frame after PPU idle");

		// NMI vector fetch also ends the frame
		scanline_group();
		cpu_read(16'hFFFA, stat);
		cpu_read(16'h5204, stat);
		check(stat[6], 1'b0, "In frame after vector fetch");

		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
src/mmc5_pkg.sv
src/mmc5_regs.sv
src/mmc5_prg_map.sv
src/mmc5_chr_map.sv
src/mmc5_scanline.sv
src/mmc5_mapper.sv
verif/tb_mmc5_mapper.sv
